// File: logic/bpu_pkg.sv
package bpu_pkg;

    // pair address bits split into index and tag
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    localparam int BTB_TAG_W   = 25;
    localparam int BTB_IDX_LSB = 3;
    localparam int BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_W;

    // full byte address as seen by the buffer
    localparam int BTB_ADDR_W = BTB_TAG_LSB + BTB_TAG_W;

    // one bit per instruction slot of the fetched pair
    typedef logic [1:0] pred_slot_t;

    localparam pred_slot_t PRED_NONE  = 2'b00;
    localparam pred_slot_t PRED_SLOT0 = 2'b01;
    localparam pred_slot_t PRED_SLOT1 = 2'b10;

    typedef logic [BTB_IDX_W-1:0] btb_index_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    // slot is pc bit 2 of the branch itself
    typedef struct packed {
        logic                  valid;
        btb_tag_t              tag;
        logic                  slot;
        logic [BTB_ADDR_W-1:0] target;
    } btb_entry_t;

    // training request from execute
    typedef struct packed {
        logic                  valid;
        logic [BTB_ADDR_W-1:0] pc;
        logic [BTB_ADDR_W-1:0] target;
        logic                  taken;
    } btb_update_t;

endpackage

// File: logic/fetch_pkg.sv
package fetch_pkg;
    import bpu_pkg::*;

    // byte address of an instruction
    typedef logic [31:0] addr_t;

    localparam addr_t PC_RESET = 32'h1c000000;

    // two 4-byte slots per aligned pair
    localparam int INSTR_BYTES = 4;
    localparam int PAIR_BYTES  = 2 * INSTR_BYTES;

    // packet queue sizing
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // next_pc is either the predicted target or the sequential successor
    typedef struct packed {
        addr_t      pc;
        pred_slot_t taken;
        addr_t      next_pc;
        logic       rsvd;
    } fetch_pkt_t;

endpackage

// File: logic/pc_gen.sv
`timescale 1ns/1ps

module pc_gen
    import fetch_pkg::*;
    import bpu_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,

    input  redirect_t  redirect_id,
    input  redirect_t  redirect_ex,
    input  redirect_t  redirect_wb,

    input  logic       allowin,

    input  pred_slot_t pred_taken,
    input  addr_t      pred_pc,

    output addr_t      fetch_pc,
    output logic       push,
    output fetch_pkt_t push_pkt,
    output logic       flush
);

    addr_t pc_q;
    addr_t pc_d;
    addr_t seq_pc;
    addr_t adv_pc;
    logic  fetch_en_q;

    // upper slot steps by one instruction, aligned pc by a whole pair
    assign seq_pc = pc_q[2] ? pc_q + addr_t'(INSTR_BYTES) : pc_q + addr_t'(PAIR_BYTES);

    // any predicted slot overrides the sequential successor
    assign adv_pc = (pred_taken != PRED_NONE) ? pred_pc : seq_pc;

    assign flush = redirect_wb.valid | redirect_ex.valid | redirect_id.valid;

    // no packet while a redirect is in flight or before fetch is enabled
    assign push = fetch_en_q & allowin & ~flush;

    // writeback beats execute beats decode
    always_comb begin
        if (redirect_wb.valid) begin
            pc_d = redirect_wb.target;
        end else if (redirect_ex.valid) begin
            pc_d = redirect_ex.target;
        end else if (redirect_id.valid) begin
            pc_d = redirect_id.target;
        end else if (push) begin
            pc_d = adv_pc;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q       <= PC_RESET;
            fetch_en_q <= 1'b0;
        end else begin
            pc_q       <= pc_d;
            fetch_en_q <= 1'b1;
        end
    end

    assign fetch_pc = pc_q;

    assign push_pkt = '{
        pc:      pc_q,
        taken:   pred_taken,
        next_pc: adv_pc,
        rsvd:    1'b0
    };

endmodule

// File: logic/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer
    import fetch_pkg::*;
    import bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,

    input  addr_t       fetch_pc,
    output pred_slot_t  pred_taken,
    output addr_t       pred_pc,

    input  btb_update_t btb_update
);

    btb_entry_t btb_mem [BTB_ENTRIES];

    btb_index_t rd_idx;
    btb_tag_t   rd_tag;
    btb_entry_t rd_entry;
    logic       rd_hit;

    btb_index_t upd_idx;
    btb_tag_t   upd_tag;
    logic       upd_hit;

    // lookup side
    assign rd_idx   = fetch_pc[BTB_IDX_LSB +: BTB_IDX_W];
    assign rd_tag   = fetch_pc[BTB_TAG_LSB +: BTB_TAG_W];
    assign rd_entry = btb_mem[rd_idx];
    assign rd_hit   = rd_entry.valid && (rd_entry.tag == rd_tag);

    // a slot-0 branch is behind us once fetch starts at the upper slot
    always_comb begin
        pred_taken = PRED_NONE;
        if (rd_hit) begin
            if (rd_entry.slot) begin
                pred_taken = PRED_SLOT1;
            end else if (!fetch_pc[2]) begin
                pred_taken = PRED_SLOT0;
            end
        end
    end

    // only meaningful when pred_taken is nonzero
    assign pred_pc = rd_entry.target;

    // training side
    assign upd_idx = btb_update.pc[BTB_IDX_LSB +: BTB_IDX_W];
    assign upd_tag = btb_update.pc[BTB_TAG_LSB +: BTB_TAG_W];
    assign upd_hit = btb_mem[upd_idx].valid && (btb_mem[upd_idx].tag == upd_tag);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_mem[i].valid <= 1'b0;
            end
        end else if (btb_update.valid) begin
            if (btb_update.taken) begin
                // install, replacing whatever shared the index
                btb_mem[upd_idx] <= '{
                    valid:  1'b1,
                    tag:    upd_tag,
                    slot:   btb_update.pc[2],
                    target: btb_update.target
                };
            end else if (upd_hit) begin
                btb_mem[upd_idx].valid <= 1'b0;
            end
        end
    end

endmodule

// File: logic/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,

    input  logic       push,
    input  fetch_pkt_t push_pkt,
    input  logic       flush,
    input  logic       pkt_take,

    output logic       allowin,
    output fetch_pkt_t pkt,
    output logic       pkt_valid
);

    typedef enum logic [1:0] {
        Q_EMPTY,
        Q_PARTIAL,
        Q_FULL
    } queue_state_t;

    queue_state_t state_q;
    queue_state_t state_d;

    fetch_pkt_t        buf_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QCNT_W-1:0] count_q;
    logic [QCNT_W-1:0] count_d;

    logic pop;
    logic wr_en;

    assign pkt_valid = (state_q != Q_EMPTY);
    assign pop       = pkt_take & pkt_valid;

    // a full queue still accepts when the head leaves this cycle
    assign allowin = (state_q != Q_FULL) | pop;
    assign wr_en   = push & allowin;

    assign count_d = count_q + QCNT_W'(wr_en) - QCNT_W'(pop);

    always_comb begin
        if (count_d == '0) begin
            state_d = Q_EMPTY;
        end else if (count_d == QCNT_W'(QUEUE_DEPTH)) begin
            state_d = Q_FULL;
        end else begin
            state_d = Q_PARTIAL;
        end
    end

    // flush drops the queue contents and this cycle's push
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            state_q  <= Q_EMPTY;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_d;
            state_q <= state_d;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            buf_mem[wr_ptr_q] <= push_pkt;
        end
    end

    assign pkt = buf_mem[rd_ptr_q];

endmodule

// File: logic/fetch_front.sv
`timescale 1ns/1ps

module fetch_front
    import fetch_pkg::*;
    import bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,

    input  redirect_t   redirect_id,
    input  redirect_t   redirect_ex,
    input  redirect_t   redirect_wb,

    input  btb_update_t btb_update,

    input  logic        pkt_take,

    output addr_t       fetch_pc,
    output fetch_pkt_t  pkt,
    output logic        pkt_valid
);

    pred_slot_t pred_taken;
    addr_t      pred_pc;
    logic       allowin;
    logic       push;
    logic       flush;
    fetch_pkt_t push_pkt;

    // next-pc selection
    pc_gen pc_gen_inst (
        .clk         (clk),
        .rstn        (rstn),
        .redirect_id (redirect_id),
        .redirect_ex (redirect_ex),
        .redirect_wb (redirect_wb),
        .allowin     (allowin),
        .pred_taken  (pred_taken),
        .pred_pc     (pred_pc),
        .fetch_pc    (fetch_pc),
        .push        (push),
        .push_pkt    (push_pkt),
        .flush       (flush)
    );

    // prediction lookup and training
    branch_target_buffer branch_target_buffer_inst (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_pc   (fetch_pc),
        .pred_taken (pred_taken),
        .pred_pc    (pred_pc),
        .btb_update (btb_update)
    );

    // packets toward decode
    fetch_queue fetch_queue_inst (
        .clk       (clk),
        .rstn      (rstn),
        .push      (push),
        .push_pkt  (push_pkt),
        .flush     (flush),
        .pkt_take  (pkt_take),
        .allowin   (allowin),
        .pkt       (pkt),
        .pkt_valid (pkt_valid)
    );

endmodule

// File: tests/fetch_front_chk.sv
`timescale 1ns/1ps

module fetch_front_chk
    import fetch_pkg::*;
(
    input logic              clk,
    input logic              rstn,
    input redirect_t         redirect_id,
    input redirect_t         redirect_ex,
    input redirect_t         redirect_wb,
    input logic              allowin,
    input addr_t             fetch_pc,
    input logic              pkt_valid,
    input logic [QCNT_W-1:0] count
);

    logic redirect_any;

    // number of assertion failures so far
    int failures = 0;

    assign redirect_any = redirect_id.valid | redirect_ex.valid | redirect_wb.valid;

    // queue leaves reset empty
    reset_empty: assert property (@(posedge clk) !rstn |=> !pkt_valid)
        else begin
            failures++;
            $error("pkt_valid high right after reset");
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (!allowin && !redirect_any) |=> fetch_pc == $past(fetch_pc))
        else begin
            failures++;
            $error("fetch_pc moved while the queue refused packets");
        end

    wb_redirect: assert property (@(posedge clk) disable iff (!rstn)
        redirect_wb.valid |=> fetch_pc == $past(redirect_wb.target))
        else begin
            failures++;
            $error("fetch_pc missed the writeback target");
        end

    count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= QUEUE_DEPTH)
        else begin
            failures++;
            $error("queue count above its depth");
        end

endmodule

bind fetch_front fetch_front_chk fetch_front_chk_inst (
    .clk         (clk),
    .rstn        (rstn),
    .redirect_id (redirect_id),
    .redirect_ex (redirect_ex),
    .redirect_wb (redirect_wb),
    .allowin     (allowin),
    .fetch_pc    (fetch_pc),
    .pkt_valid   (pkt_valid),
    .count       (fetch_queue_inst.count_q)
);

// File: tests/tb_fetch_front.sv
`timescale 1ns/1ps

module tb_fetch_front
    import fetch_pkg::*;
    import bpu_pkg::*;
();

    // upper bound on the whole run
    localparam int    TIMEOUT_CYCLES = 2000;
    localparam int    WAIT_LIMIT     = 16;
    localparam int    SRC_ID         = 0;
    localparam int    SRC_EX         = 1;
    localparam int    SRC_WB         = 2;
    localparam addr_t PAIR_B         = 32'h2000_0040;
    localparam addr_t PAIR_C         = 32'h2000_0080;

    logic        clk = 1'b0;
    logic        rstn;
    redirect_t   redirect_id;
    redirect_t   redirect_ex;
    redirect_t   redirect_wb;
    btb_update_t btb_update;
    logic        pkt_take;
    addr_t       fetch_pc;
    fetch_pkt_t  pkt;
    logic        pkt_valid;

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    addr_t exp_pc;

    // reference buffer keeps the full branch pc per pair index
    logic  ref_valid [BTB_ENTRIES];
    addr_t ref_pc    [BTB_ENTRIES];
    addr_t ref_tgt   [BTB_ENTRIES];

    fetch_front fetch_front_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic int pair_index(input addr_t pc);
        return (pc / PAIR_BYTES) % BTB_ENTRIES;
    endfunction

    function automatic logic ref_hit(input addr_t pc);
        int i;
        i = pair_index(pc);
        return ref_valid[i] && (ref_pc[i] / (PAIR_BYTES * BTB_ENTRIES) ==
                                pc / (PAIR_BYTES * BTB_ENTRIES));
    endfunction

    // slot 1 covers the whole pair, slot 0 only an aligned fetch
    function automatic pred_slot_t ref_predict(input addr_t pc);
        if (!ref_hit(pc)) return 2'b00;
        if (ref_pc[pair_index(pc)][2]) return 2'b10;
        return pc[2] ? 2'b00 : 2'b01;
    endfunction

    function automatic addr_t ref_next(input addr_t pc);
        if (ref_predict(pc) != 2'b00) return ref_tgt[pair_index(pc)];
        return pc[2] ? pc + 32'd4 : pc + 32'd8;
    endfunction

    function automatic addr_t rand_addr();
        return $urandom & 32'hffff_fffc;
    endfunction

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic train(input addr_t pc, input addr_t target, input logic taken);
        int i;
        i = pair_index(pc);
        btb_update = '{valid: 1'b1, pc: pc, target: target, taken: taken};
        step();
        btb_update = '0;
        if (taken) begin
            ref_valid[i] = 1'b1;
            ref_pc[i]    = pc;
            ref_tgt[i]   = target;
        end else if (ref_hit(pc)) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    task automatic redirect_to(input int src, input addr_t target);
        pkt_take = 1'b0;
        case (src)
            SRC_ID:  redirect_id = '{valid: 1'b1, target: target};
            SRC_EX:  redirect_ex = '{valid: 1'b1, target: target};
            default: redirect_wb = '{valid: 1'b1, target: target};
        endcase
        step();
        redirect_id = '0;
        redirect_ex = '0;
        redirect_wb = '0;
        check("fetch_pc after redirect", fetch_pc, target);
        check("pkt_valid after flush", pkt_valid, 1'b0);
        exp_pc = target;
    endtask

    // look at the head without popping it
    task automatic expect_head(input pred_slot_t exp_taken, input addr_t exp_next);
        int waited;
        waited = 0;
        while (!pkt_valid && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (!pkt_valid) begin
            $display("no packet reached the queue head by %0t ns", $time);
            errors++;
        end else begin
            check("head taken", pkt.taken, exp_taken);
            check("head next_pc", pkt.next_pc, exp_next);
        end
    endtask

    task automatic take_and_check(input int n);
        int got;
        int waited;
        got = 0;
        waited = 0;
        while (got < n && waited < WAIT_LIMIT) begin
            if (pkt_valid) begin
                check("pkt.pc", pkt.pc, exp_pc);
                check("pkt.taken", pkt.taken, ref_predict(exp_pc));
                check("pkt.next_pc", pkt.next_pc, ref_next(exp_pc));
                check("pkt.rsvd", pkt.rsvd, 1'b0);
                exp_pc = ref_next(exp_pc);
                pkt_take = 1'b1;
                got++;
                waited = 0;
            end else begin
                pkt_take = 1'b0;
                waited++;
            end
            step();
        end
        pkt_take = 1'b0;
        if (got < n) begin
            $display("only %0d of %0d packets arrived by %0t ns", got, n, $time);
            errors++;
        end
    endtask

    task automatic test_sequential();
        check("fetch_pc after reset", fetch_pc, PC_RESET);
        check("pkt_valid after reset", pkt_valid, 1'b0);
        exp_pc = PC_RESET;
        take_and_check(6);
        // an upper slot start steps by 4 once and then by pairs
        redirect_to(SRC_WB, PC_RESET + 32'h104);
        take_and_check(4);
    endtask

    task automatic test_redirect_priority();
        addr_t tw;
        addr_t te;
        addr_t td;
        tw = rand_addr();
        te = rand_addr();
        td = rand_addr();
        repeat (3) step();
        check("queue holds packets", pkt_valid, 1'b1);
        redirect_wb = '{valid: 1'b1, target: tw};
        redirect_ex = '{valid: 1'b1, target: te};
        redirect_id = '{valid: 1'b1, target: td};
        step();
        check("writeback wins", fetch_pc, tw);
        check("queue flushed", pkt_valid, 1'b0);
        redirect_wb = '0;
        step();
        check("execute beats decode", fetch_pc, te);
        redirect_ex = '0;
        step();
        check("decode target", fetch_pc, td);
        check("queue still empty", pkt_valid, 1'b0);
        redirect_id = '0;
        step();
        check("first packet valid", pkt_valid, 1'b1);
        check("first packet pc", pkt.pc, td);
        exp_pc = td;
        take_and_check(3);
    endtask

    task automatic test_back_pressure();
        addr_t hold;
        hold = 32'h1c00_1000;
        redirect_to(SRC_EX, hold);
        repeat (QUEUE_DEPTH) hold = ref_next(hold);
        repeat (QUEUE_DEPTH + 3) step();
        check("fetch_pc stalled", fetch_pc, hold);
        check("head is oldest", pkt.pc, 32'h1c00_1000);
        step();
        step();
        check("fetch_pc still stalled", fetch_pc, hold);
        take_and_check(QUEUE_DEPTH + 4);
    endtask

    task automatic test_btb_predict();
        addr_t tgt_b;
        addr_t tgt_c;
        tgt_b = rand_addr();
        tgt_c = rand_addr();
        train(PAIR_B + 32'd4, tgt_b, 1'b1);
        redirect_to(SRC_WB, PAIR_B);
        expect_head(2'b10, tgt_b);
        take_and_check(3);
        // slot 1 also applies to a fetch that starts at the upper slot
        redirect_to(SRC_EX, PAIR_B + 32'd4);
        expect_head(2'b10, tgt_b);
        take_and_check(2);
        train(PAIR_C, tgt_c, 1'b1);
        redirect_to(SRC_ID, PAIR_C + 32'd4);
        expect_head(2'b00, PAIR_C + 32'd8);
        take_and_check(2);
        redirect_to(SRC_WB, PAIR_C);
        expect_head(2'b01, tgt_c);
        take_and_check(2);
    endtask

    task automatic test_btb_remove();
        addr_t alias_pc;
        addr_t tgt;
        alias_pc = PAIR_B + addr_t'(PAIR_BYTES * BTB_ENTRIES);
        tgt = rand_addr();
        train(PAIR_B + 32'd4, 32'd0, 1'b0);
        redirect_to(SRC_WB, PAIR_B);
        expect_head(2'b00, PAIR_B + 32'd8);
        take_and_check(2);
        train(PAIR_B + 32'd4, tgt, 1'b1);
        redirect_to(SRC_EX, alias_pc);
        expect_head(2'b00, alias_pc + 32'd8);
        take_and_check(2);
        // miss on the alias must leave the installed entry alone
        train(alias_pc + 32'd4, 32'd0, 1'b0);
        redirect_to(SRC_WB, PAIR_B);
        expect_head(2'b10, tgt);
        take_and_check(2);
    endtask

    initial begin
        rstn        = 1'b0;
        redirect_id = '0;
        redirect_ex = '0;
        redirect_wb = '0;
        btb_update  = '0;
        pkt_take    = 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
        void'($urandom(32'ha19e8325));
        repeat (8) @(posedge clk);
        #5;
        rstn = 1'b1;
        test_sequential();
        test_redirect_priority();
        test_back_pressure();
        test_btb_predict();
        test_btb_remove();
        // bound assertion failures count as errors too
        errors += fetch_front_inst.fetch_front_chk_inst.failures;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/bpu_pkg.sv
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/branch_target_buffer.sv
logic/fetch_queue.sv
logic/fetch_front.sv
tests/fetch_front_chk.sv
tests/tb_fetch_front.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_front -f tb.f -o sim_fetch_front

./obj_dir/sim_fetch_front > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
